// File: logic/uart_pkg.sv
package uart_pkg;

    // One character on the serial line
    typedef logic [7:0] uart_byte_t;

    // Clock cycles per bit, 4 or more
    typedef logic [15:0] baud_div_t;

    // Receiver result, valid pulses once per frame
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
        logic       frame_err;
    } uart_rx_t;

    typedef enum logic {
        TX_IDLE,
        TX_WORK
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

// File: logic/wb_pkg.sv
package wb_pkg;

    typedef logic [3:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // Register map, byte addresses
    localparam wb_addr_t ADDR_TXDATA  = 4'h0;
    localparam wb_addr_t ADDR_RXDATA  = 4'h4;
    localparam wb_addr_t ADDR_STATUS  = 4'h8;
    localparam wb_addr_t ADDR_DIVISOR = 4'hC;

    // Status bits
    localparam int STAT_TX_BUSY   = 0;
    localparam int STAT_RX_VALID  = 1;
    localparam int STAT_FRAME_ERR = 2;
    localparam int STAT_OVERRUN   = 3;

endpackage

// File: logic/uart_regs.sv
`timescale 1ns/1ps

module uart_regs #(
    parameter int CLOCK_FREQ = 125_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  logic                clk,
    input  logic                rst_n,
    input  wb_pkg::wb_req_t     wb_req,
    output wb_pkg::wb_rsp_t     wb_rsp,
    output logic                tx_valid,
    input  logic                tx_ready,
    output uart_pkg::uart_byte_t tx_data,
    input  uart_pkg::uart_rx_t  rx,
    output uart_pkg::baud_div_t divisor
);
    import wb_pkg::*;
    import uart_pkg::*;

    localparam baud_div_t DIV_RESET = baud_div_t'(CLOCK_FREQ / BAUD_RATE);

    logic       ack_q;
    wb_data_t   rdata_q;
    wb_data_t   rdata;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       frame_err;
    logic       overrun;

    logic access;
    logic tx_write;
    logic done;
    logic rd_rx;
    logic rd_status;
    logic wr_div;

    // New access seen, not yet acknowledged
    assign access    = wb_req.cyc && wb_req.stb && !ack_q;
    assign tx_write  = access && wb_req.we && (wb_req.adr == ADDR_TXDATA);
    assign rd_rx     = access && !wb_req.we && (wb_req.adr == ADDR_RXDATA);
    assign rd_status = access && !wb_req.we && (wb_req.adr == ADDR_STATUS);
    assign wr_div    = access && wb_req.we && (wb_req.adr == ADDR_DIVISOR);

    // TXDATA write stays open until the transmitter takes the byte
    assign tx_valid = tx_write;
    assign tx_data  = wb_req.dat[7:0];
    assign done     = tx_write ? tx_ready : access;

    always_comb begin
        rdata = '0;
        case (wb_req.adr)
            ADDR_RXDATA: rdata[7:0] = rx_data;
            ADDR_STATUS: begin
                rdata[STAT_TX_BUSY]   = !tx_ready;
                rdata[STAT_RX_VALID]  = rx_valid;
                rdata[STAT_FRAME_ERR] = frame_err;
                rdata[STAT_OVERRUN]   = overrun;
            end
            ADDR_DIVISOR: rdata[15:0] = divisor;
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
            divisor <= DIV_RESET;
        end else begin
            ack_q <= done;
            if (access) begin
                rdata_q <= rdata;
            end
            if (wr_div) begin
                divisor <= wb_req.dat[15:0];
            end
        end
    end

    // Receive holder and sticky flags, new events win over clears
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            if (rd_rx) begin
                rx_valid <= 1'b0;
            end
            if (rd_status) begin
                frame_err <= 1'b0;
                overrun   <= 1'b0;
            end
            if (rx.valid) begin
                rx_valid <= 1'b1;
                if (rx.frame_err) begin
                    frame_err <= 1'b1;
                end
                if (rx_valid && !rd_rx) begin
                    overrun <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx.valid) begin
            rx_data <= rx.data;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rdata_q};

endmodule

// File: logic/uart_transmitter.sv
`timescale 1ns/1ps

module uart_transmitter (
    input  logic                 clk,
    input  logic                 rst_n,

    // Byte handoff
    input  logic                 tx_valid,
    input  uart_pkg::uart_byte_t tx_data,
    output logic                 tx_ready,

    input  uart_pkg::baud_div_t  divisor,
    output logic                 serial_out
);
    import uart_pkg::*;

    tx_state_t state;
    logic [9:0] tx_shift;
    logic [3:0] bit_counter;
    baud_div_t  clock_counter;
    baud_div_t  div_q;

    logic is_symbol_edge;
    logic tx_fire;

    assign is_symbol_edge = (clock_counter == div_q - baud_div_t'(1));
    assign tx_fire        = tx_valid && tx_ready;

    assign tx_ready   = (state == TX_IDLE);
    assign serial_out = (state == TX_WORK) ? tx_shift[0] : 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= TX_IDLE;
            bit_counter   <= '0;
            clock_counter <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    bit_counter   <= '0;
                    clock_counter <= '0;
                    if (tx_fire) begin
                        state <= TX_WORK;
                    end
                end
                TX_WORK: begin
                    if (is_symbol_edge) begin
                        clock_counter <= '0;
                        bit_counter   <= bit_counter + 4'd1;
                        // Stop bit done
                        if (bit_counter == 4'd9) begin
                            state <= TX_IDLE;
                        end
                    end else begin
                        clock_counter <= clock_counter + baud_div_t'(1);
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Frame goes out LSB first, start bit in bit 0
    always_ff @(posedge clk) begin
        if (tx_fire) begin
            tx_shift <= {1'b1, tx_data, 1'b0};
            div_q    <= divisor;
        end else if (state == TX_WORK && is_symbol_edge) begin
            tx_shift <= {1'b1, tx_shift[9:1]};
        end
    end

endmodule

// File: logic/uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                serial_in,
    input  uart_pkg::baud_div_t divisor,
    output uart_pkg::uart_rx_t  rx
);
    import uart_pkg::*;

    rx_state_t  state;
    logic [1:0] sync;
    logic       line_prev;
    baud_div_t  div_q;
    baud_div_t  clock_counter;
    logic [2:0] bit_counter;
    uart_byte_t rx_shift;
    logic       valid_q;
    logic       frame_err_q;

    logic line;
    logic falling;
    logic half_bit;
    logic full_bit;

    assign line     = sync[1];
    assign falling  = line_prev && !line;
    assign half_bit = (clock_counter == (div_q >> 1) - baud_div_t'(1));
    assign full_bit = (clock_counter == div_q - baud_div_t'(1));

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync      <= 2'b11;
            line_prev <= 1'b1;
        end else begin
            sync      <= {sync[0], serial_in};
            line_prev <= line;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= RX_IDLE;
            clock_counter <= '0;
            bit_counter   <= '0;
            valid_q       <= 1'b0;
            frame_err_q   <= 1'b0;
        end else begin
            valid_q       <= 1'b0;
            clock_counter <= clock_counter + baud_div_t'(1);
            case (state)
                RX_IDLE: begin
                    clock_counter <= '0;
                    bit_counter   <= '0;
                    if (falling) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Start bit must still be low at mid-bit
                    if (half_bit) begin
                        clock_counter <= '0;
                        state <= line ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (full_bit) begin
                        clock_counter <= '0;
                        bit_counter   <= bit_counter + 3'd1;
                        if (bit_counter == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (full_bit) begin
                        valid_q     <= 1'b1;
                        frame_err_q <= !line;
                        state       <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_IDLE && falling) begin
            div_q <= divisor;
        end
        if (state == RX_DATA && full_bit) begin
            rx_shift <= {line, rx_shift[7:1]};
        end
    end

    assign rx = '{valid: valid_q, data: rx_shift, frame_err: frame_err_q};

endmodule

// File: logic/uart_top.sv
`timescale 1ns/1ps

module uart_top #(
    parameter int CLOCK_FREQ = 125_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp,
    input  logic            serial_in,
    output logic            serial_out
);
    import uart_pkg::*;

    logic       tx_valid;
    logic       tx_ready;
    uart_byte_t tx_data;
    baud_div_t  divisor;
    uart_rx_t   rx;

    uart_regs #(
        .CLOCK_FREQ(CLOCK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .tx_data (tx_data),
        .rx      (rx),
        .divisor (divisor)
    );

    uart_transmitter u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .divisor   (divisor),
        .serial_out(serial_out)
    );

    uart_receiver u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .serial_in(serial_in),
        .divisor  (divisor),
        .rx       (rx)
    );

endmodule

// File: dv/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;
    import wb_pkg::*;
    import uart_pkg::*;

    localparam int DIV            = 10;
    localparam int CLK_PERIOD     = 10;
    localparam int STALL_LIMIT    = 400;
    localparam int POLL_LIMIT     = 200;
    localparam int TIMEOUT_CYCLES = 20_000;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    serial_in;
    logic    serial_out;

    logic   loopback;
    logic   drv_line;
    int     cycles = 0;
    integer seed = 32'h671facf9;
    time    ack_time;

    uart_top #(
        .CLOCK_FREQ(1_000_000),
        .BAUD_RATE (100_000)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .serial_in (serial_in),
        .serial_out(serial_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Line source is the transmitter loopback or the serial driver below
    always @(posedge clk) begin
        serial_in <= loopback ? serial_out : drv_line;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error("Timeout: tests did not finish within the cycle limit");
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error("Value mismatch");
        end
    endtask

    // One classic cycle held until ack seen on the falling clock edge
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                             output wb_data_t rdat);
        int stall;
        stall = 0;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        while (!wb_rsp.ack) begin
            stall++;
            if (stall >= STALL_LIMIT) begin
                stop_on_error("Bus access was not acknowledged within 400 cycles");
            end
            @(negedge clk);
        end
        rdat     = wb_rsp.dat;
        ack_time = $time;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t wdat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdat);
        bus_cycle(1'b0, adr, '0, rdat);
    endtask

    task automatic wait_status(input int bit_pos, output wb_data_t status);
        int polls;
        polls = 0;
        wb_read(ADDR_STATUS, status);
        while (!status[bit_pos]) begin
            polls++;
            if (polls >= POLL_LIMIT) begin
                stop_on_error("Status flag never came up while polling STATUS");
            end
            wb_read(ADDR_STATUS, status);
        end
    endtask

    // Mid-bit sampling of one frame on serial_out
    task automatic capture_frame(output uart_byte_t data, output logic stop,
                                 output time t_start);
        @(negedge serial_out);
        t_start = $time;
        repeat (DIV / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            repeat (DIV) @(negedge clk);
            data[i] = serial_out;
        end
        repeat (DIV) @(negedge clk);
        stop = serial_out;
    endtask

    task automatic send_frame(input uart_byte_t data, input int div, input logic stop);
        logic [9:0] frame;
        frame = {stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            drv_line <= frame[i];
            repeat (div - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_line <= 1'b1;
    endtask

    task automatic test_reset();
        wb_data_t rd;
        wb_read(ADDR_STATUS, rd);
        check("status", rd, 32'h0);
        wb_read(ADDR_DIVISOR, rd);
        check("divisor", rd, DIV);
        check("serial_out", serial_out, 1'b1);
    endtask

    task automatic test_divisor();
        wb_data_t rd;
        wb_write(ADDR_DIVISOR, 32'd16);
        wb_read(ADDR_DIVISOR, rd);
        check("divisor", rd, 32'd16);
        wb_write(ADDR_DIVISOR, DIV);
        wb_read(ADDR_DIVISOR, rd);
        check("divisor", rd, DIV);
    endtask

    task automatic test_tx_frame();
        uart_byte_t data;
        uart_byte_t got;
        logic       stop;
        time        t_start;
        wb_data_t   rd;
        data = $random(seed);
        fork
            capture_frame(got, stop, t_start);
            begin
                wb_write(ADDR_TXDATA, data);
                wb_read(ADDR_STATUS, rd);
                check("status.tx_busy", rd[STAT_TX_BUSY], 1'b1);
            end
        join
        check("serial_out byte", got, data);
        check("serial_out stop bit", stop, 1'b1);
        repeat (DIV) @(posedge clk);
        wb_read(ADDR_STATUS, rd);
        check("status.tx_busy", rd[STAT_TX_BUSY], 1'b0);
    endtask

    task automatic test_back_pressure();
        uart_byte_t b1;
        uart_byte_t b2;
        uart_byte_t got1;
        uart_byte_t got2;
        logic       stop1;
        logic       stop2;
        time        t1;
        time        t2;
        time        second_ack;
        b1 = $random(seed);
        b2 = $random(seed);
        fork
            begin
                wb_write(ADDR_TXDATA, b1);
                wb_write(ADDR_TXDATA, b2);
                second_ack = ack_time;
            end
            begin
                capture_frame(got1, stop1, t1);
                capture_frame(got2, stop2, t2);
            end
        join
        // Second write may only complete once the first stop bit is over
        check("second ack after first frame", second_ack >= t1 + 10 * DIV * CLK_PERIOD, 1'b1);
        check("first byte", got1, b1);
        check("first stop bit", stop1, 1'b1);
        check("second byte", got2, b2);
        check("second stop bit", stop2, 1'b1);
    endtask

    task automatic test_loopback();
        uart_byte_t data;
        wb_data_t   rd;
        data = $random(seed);
        @(posedge clk);
        loopback <= 1'b1;
        wb_write(ADDR_TXDATA, data);
        wait_status(STAT_RX_VALID, rd);
        check("status on rx_valid", rd & 32'hE, 32'h2);
        wb_read(ADDR_RXDATA, rd);
        check("rxdata", rd, data);
        wb_read(ADDR_STATUS, rd);
        check("status rx flags", rd & 32'hE, 32'h0);
        @(posedge clk);
        loopback <= 1'b0;
    endtask

    task automatic test_error_flags();
        uart_byte_t bad;
        uart_byte_t b1;
        uart_byte_t b2;
        wb_data_t   rd;
        bad = $random(seed);
        b1  = $random(seed);
        b2  = $random(seed);
        send_frame(bad, DIV, 1'b0);
        wait_status(STAT_FRAME_ERR, rd);
        check("status", rd, 32'h6);
        wb_read(ADDR_STATUS, rd);
        check("status.frame_err", rd[STAT_FRAME_ERR], 1'b0);
        wb_read(ADDR_RXDATA, rd);
        check("rxdata", rd, bad);
        // Two good frames with nothing read in between
        send_frame(b1, DIV, 1'b1);
        send_frame(b2, DIV, 1'b1);
        wait_status(STAT_OVERRUN, rd);
        check("status", rd, 32'hA);
        wb_read(ADDR_RXDATA, rd);
        check("rxdata", rd, b2);
    endtask

    initial begin
        clk = 1'b0;
        rst_n     <= 1'b0;
        wb_req    <= '0;
        serial_in <= 1'b1;
        loopback  <= 1'b0;
        drv_line  <= 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_divisor();
        test_tx_frame();
        test_back_pressure();
        test_loopback();
        test_error_flags();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: verilog.f
logic/uart_pkg.sv
logic/wb_pkg.sv
logic/uart_regs.sv
logic/uart_transmitter.sv
logic/uart_receiver.sv
logic/uart_top.sv
dv/uart_tb.sv
